//--- common/cpuPkg.sv
// Shared widths, fields, encodings and control structs of the bus CPU, imported by every RTL block
package cpuPkg;

   localparam int wordWidth = 32;
   localparam int addressWidth = 8;

   // Longest phase in steps; fetch and execute each count from zero
   localparam int maxSteps = 8;
   localparam int stepWidth = $clog2(maxSteps);

   // Instruction fields
   localparam int opcodeMsb = 31;
   localparam int opcodeLsb = 27;
   localparam int raMsb = 26;
   localparam int raLsb = 23;
   localparam int rbMsb = 22;
   localparam int rbLsb = 19;
   localparam int rcMsb = 18;
   localparam int rcLsb = 15;
   localparam int immMsb = 18;

   // Branch condition in the low bits of the rb field
   localparam int condWidth = 2;
   localparam logic [condWidth-1:0] condZero = 2'd0;
   localparam logic [condWidth-1:0] condNonzero = 2'd1;

   // Branch targets are relative to PC, which already points past the instruction
   typedef enum logic [4:0] {
      opAdd = 5'd0,
      opSub = 5'd1,
      opAnd = 5'd2,
      opOr = 5'd3,
      opAddi = 5'd4,
      opLd = 5'd5,
      opSt = 5'd6,
      opJal = 5'd7,
      opJr = 5'd8,
      opBrzr = 5'd9,
      opBrnz = 5'd10,
      opHalt = 5'd11
   } opcodeT;

   typedef enum logic [2:0] {
      aluAdd = 3'd0,
      aluSub = 3'd1,
      aluAnd = 3'd2,
      aluOr = 3'd3,
      aluPassB = 3'd4,
      aluInc = 3'd5
   } aluOpT;

   typedef enum logic [3:0] {
      busNone = 4'd0,
      busReg = 4'd1,
      busPc = 4'd2,
      busMdr = 4'd3,
      busZlo = 4'd4,
      busImm = 4'd5,
      busPcLink = 4'd6
   } busSourceT;

   typedef struct packed {
      busSourceT busSource;
      logic pcIn;
      logic irIn;
      logic yIn;
      logic zIn;
      logic marIn;
      logic mdrIn;
      logic conIn;
      logic rIn;
      logic rOut;
      logic gra;
      logic grb;
      logic grc;
      logic baOut;
      aluOpT aluOp;
      logic memRead;
      logic memWrite;
      logic incPc;
   } controlWordT;

   typedef struct packed {
      logic [wordWidth-1:0] ir;
      logic conFlag;
   } statusT;

endpackage

//--- datapath/registerFile.sv
// General register file of the datapath; one write and one read port, register chosen by an IR field
`timescale 1ns/10ps
module registerFile (
   input  logic Clock,
   input  logic reset,
   input  logic [cpuPkg::wordWidth-1:0] irWord,
   input  logic gra,
   input  logic grb,
   input  logic grc,
   input  logic rIn,
   input  logic rOut,
   input  logic baOut,
   input  logic [cpuPkg::wordWidth-1:0] busIn,
   output logic [cpuPkg::wordWidth-1:0] readData
);
   import cpuPkg::*;

   logic [wordWidth-1:0] registers [16];
   logic [3:0] select;

   // Field select, ra first
   always_comb begin
      if (gra) begin
         select = irWord[raMsb:raLsb];
      end else if (grb) begin
         select = irWord[rbMsb:rbLsb];
      end else if (grc) begin
         select = irWord[rcMsb:rcLsb];
      end else begin
         select = '0;
      end
   end

   always_ff @(posedge Clock) begin
      if (reset) begin
         for (int i = 0; i < 16; i++) begin
            registers[i] <= '0;
         end
      end else if (rIn) begin
         registers[select] <= busIn;
      end
   end

   // Base addressing sees r0 as zero
   always_comb begin
      if (!rOut || (baOut && select == 4'd0)) begin
         readData = '0;
      end else begin
         readData = registers[select];
      end
   end

endmodule

//--- datapath/alu.sv
// Combinational ALU of the datapath; Y on input a, the bus on input b, result goes to Z
`timescale 1ns/10ps
module alu (
   input  cpuPkg::aluOpT operation,
   input  logic [cpuPkg::wordWidth-1:0] a,
   input  logic [cpuPkg::wordWidth-1:0] b,
   output logic [cpuPkg::wordWidth-1:0] result
);
   import cpuPkg::*;

   // All arithmetic wraps at 32 bits
   always_comb begin
      case (operation)
         aluAdd: begin
            result = a + b;
         end
         aluSub: begin
            result = a - b;
         end
         aluAnd: begin
            result = a & b;
         end
         aluOr: begin
            result = a | b;
         end
         aluPassB: begin
            result = b;
         end
         aluInc: begin
            result = b + 1'b1;
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

//--- datapath/dataPath.sv
// Datapath of the bus CPU; special registers, bus multiplexer, immediate and condition logic, steered by the control word
`timescale 1ns/10ps
module dataPath (
   input  logic Clock,
   input  logic reset,
   input  cpuPkg::controlWordT control,
   output cpuPkg::statusT status,
   output logic [cpuPkg::addressWidth-1:0] memAddress,
   output logic [cpuPkg::wordWidth-1:0] memWriteData,
   input  logic [cpuPkg::wordWidth-1:0] memReadData,
   output logic memRead,
   output logic memWrite
);
   import cpuPkg::*;

   logic [wordWidth-1:0] pc;
   logic [wordWidth-1:0] ir;
   logic [wordWidth-1:0] mdr;
   logic [wordWidth-1:0] y;
   logic [wordWidth-1:0] z;
   logic [addressWidth-1:0] mar;
   logic conFlag;
   logic readPending;
   logic [wordWidth-1:0] busValue;
   logic [wordWidth-1:0] regReadData;
   logic [wordWidth-1:0] aluResult;
   logic [wordWidth-1:0] immediate;

   registerFile u_registerFile (
      .Clock    (Clock),
      .reset    (reset),
      .irWord   (ir),
      .gra      (control.gra),
      .grb      (control.grb),
      .grc      (control.grc),
      .rIn      (control.rIn),
      .rOut     (control.rOut),
      .baOut    (control.baOut),
      .busIn    (busValue),
      .readData (regReadData)
   );

   alu u_alu (
      .operation (control.aluOp),
      .a         (y),
      .b         (busValue),
      .result    (aluResult)
   );

   assign immediate = {{(wordWidth - immMsb - 1){ir[immMsb]}}, ir[immMsb:0]};

   always_comb begin
      case (control.busSource)
         busReg: begin
            busValue = regReadData;
         end
         // After fetch PC already holds the link address
         busPc, busPcLink: begin
            busValue = pc;
         end
         busMdr: begin
            busValue = mdr;
         end
         busZlo: begin
            busValue = z;
         end
         busImm: begin
            busValue = immediate;
         end
         default: begin
            busValue = '0;
         end
      endcase
   end

   always_ff @(posedge Clock) begin
      if (reset) begin
         pc <= '0;
         ir <= '0;
         conFlag <= 1'b0;
         readPending <= 1'b0;
      end else begin
         if (control.pcIn) begin
            pc <= busValue;
         end else if (control.incPc) begin
            pc <= pc + 1'b1;
         end
         if (control.irIn) begin
            ir <= busValue;
         end
         if (control.conIn) begin
            conFlag <= (busValue == '0);
         end
         // Memory data arrives one cycle after the read strobe
         readPending <= control.memRead;
      end
   end

   always_ff @(posedge Clock) begin
      if (control.marIn) begin
         mar <= busValue[addressWidth-1:0];
      end
      if (control.mdrIn) begin
         mdr <= readPending ? memReadData : busValue;
      end
      if (control.yIn) begin
         y <= busValue;
      end
      if (control.zIn) begin
         z <= aluResult;
      end
   end

   assign memAddress = mar;
   assign memWriteData = mdr;
   assign memRead = control.memRead;
   assign memWrite = control.memWrite;
   assign status = '{ir: ir, conFlag: conFlag};

endmodule

//--- rtl/controlSequencer.sv
// Control sequencer of the bus CPU; steps through fetch and execute and issues one control word per cycle
`timescale 1ns/10ps
module controlSequencer (
   input  logic Clock,
   input  logic reset,
   input  logic run,
   input  cpuPkg::statusT status,
   output cpuPkg::controlWordT control,
   output logic halted
);
   import cpuPkg::*;

   typedef enum logic [1:0] {
      phaseIdle,
      phaseFetch,
      phaseExecute,
      phaseHalted
   } phaseT;

   localparam logic [stepWidth-1:0] fetchLast = 3;

   phaseT phase;
   logic [stepWidth-1:0] step;
   opcodeT opcode;
   logic [condWidth-1:0] condField;
   logic branchTaken;
   logic lastStep;

   function automatic aluOpT aluFor(input opcodeT op);
      case (op)
         opSub: begin
            return aluSub;
         end
         opAnd: begin
            return aluAnd;
         end
         opOr: begin
            return aluOr;
         end
         default: begin
            return aluAdd;
         end
      endcase
   endfunction

   assign opcode = opcodeT'(status.ir[opcodeMsb:opcodeLsb]);
   assign condField = status.ir[rbLsb +: condWidth];

   always_comb begin
      case (condField)
         condZero: begin
            branchTaken = status.conFlag;
         end
         condNonzero: begin
            branchTaken = !status.conFlag;
         end
         default: begin
            branchTaken = 1'b0;
         end
      endcase
   end

   // Fetch steps T0..T3, execute steps count again from zero (T4 onwards)
   always_comb begin
      control = '0;
      lastStep = 1'b0;
      if (phase == phaseFetch) begin
         case (step)
            0: begin
               control.busSource = busPc;
               control.marIn = 1'b1;
               control.incPc = 1'b1;
            end
            1: begin
               // Bus is free here, so Y picks up PC for branches
               control.memRead = 1'b1;
               control.busSource = busPc;
               control.yIn = 1'b1;
            end
            2: begin
               control.mdrIn = 1'b1;
            end
            default: begin
               control.busSource = busMdr;
               control.irIn = 1'b1;
            end
         endcase
      end else if (phase == phaseExecute) begin
         case (opcode)
            opAdd, opSub, opAnd, opOr, opAddi: begin
               lastStep = (step == 2);
               if (step == 0) begin
                  control.busSource = busReg;
                  control.rOut = 1'b1;
                  control.grb = 1'b1;
                  control.yIn = 1'b1;
               end else if (step == 1) begin
                  control.zIn = 1'b1;
                  if (opcode == opAddi) begin
                     control.busSource = busImm;
                     control.aluOp = aluAdd;
                  end else begin
                     control.busSource = busReg;
                     control.rOut = 1'b1;
                     control.grc = 1'b1;
                     control.aluOp = aluFor(opcode);
                  end
               end else begin
                  control.busSource = busZlo;
                  control.rIn = 1'b1;
                  control.gra = 1'b1;
               end
            end
            opLd: begin
               lastStep = (step == 5);
               case (step)
                  0: begin
                     control.busSource = busReg;
                     control.rOut = 1'b1;
                     control.grb = 1'b1;
                     control.baOut = 1'b1;
                     control.yIn = 1'b1;
                  end
                  1: begin
                     control.busSource = busImm;
                     control.aluOp = aluAdd;
                     control.zIn = 1'b1;
                  end
                  2: begin
                     control.busSource = busZlo;
                     control.marIn = 1'b1;
                  end
                  3: begin
                     control.memRead = 1'b1;
                  end
                  4: begin
                     control.mdrIn = 1'b1;
                  end
                  default: begin
                     control.busSource = busMdr;
                     control.rIn = 1'b1;
                     control.gra = 1'b1;
                  end
               endcase
            end
            opSt: begin
               lastStep = (step == 4);
               case (step)
                  // Data word goes to MDR first, while no read is pending
                  0: begin
                     control.busSource = busReg;
                     control.rOut = 1'b1;
                     control.gra = 1'b1;
                     control.mdrIn = 1'b1;
                  end
                  1: begin
                     control.busSource = busReg;
                     control.rOut = 1'b1;
                     control.grb = 1'b1;
                     control.baOut = 1'b1;
                     control.yIn = 1'b1;
                  end
                  2: begin
                     control.busSource = busImm;
                     control.aluOp = aluAdd;
                     control.zIn = 1'b1;
                  end
                  3: begin
                     control.busSource = busZlo;
                     control.marIn = 1'b1;
                  end
                  default: begin
                     control.memWrite = 1'b1;
                  end
               endcase
            end
            opJal: begin
               lastStep = (step == 1);
               if (step == 0) begin
                  control.busSource = busPcLink;
                  control.rIn = 1'b1;
                  control.grb = 1'b1;
               end else begin
                  control.busSource = busReg;
                  control.rOut = 1'b1;
                  control.gra = 1'b1;
                  control.pcIn = 1'b1;
               end
            end
            opJr: begin
               lastStep = 1'b1;
               control.busSource = busReg;
               control.rOut = 1'b1;
               control.gra = 1'b1;
               control.pcIn = 1'b1;
            end
            opBrzr, opBrnz: begin
               lastStep = (step == 2);
               if (step == 0) begin
                  control.busSource = busReg;
                  control.rOut = 1'b1;
                  control.gra = 1'b1;
                  control.conIn = 1'b1;
               end else if (step == 1 && branchTaken) begin
                  control.busSource = busImm;
                  control.aluOp = aluAdd;
                  control.zIn = 1'b1;
               end else if (step == 2 && branchTaken) begin
                  control.busSource = busZlo;
                  control.pcIn = 1'b1;
               end
            end
            // Halt and unknown opcodes take a single empty step
            default: begin
               lastStep = 1'b1;
            end
         endcase
      end
   end

   always_ff @(posedge Clock) begin
      if (reset) begin
         phase <= phaseIdle;
         step <= '0;
      end else begin
         case (phase)
            phaseIdle: begin
               step <= '0;
               if (run) begin
                  phase <= phaseFetch;
               end
            end
            phaseFetch: begin
               if (step == fetchLast) begin
                  phase <= phaseExecute;
                  step <= '0;
               end else begin
                  step <= step + 1'b1;
               end
            end
            phaseExecute: begin
               if (opcode == opHalt) begin
                  phase <= phaseHalted;
               end else if (lastStep) begin
                  phase <= run ? phaseFetch : phaseIdle;
                  step <= '0;
               end else begin
                  step <= step + 1'b1;
               end
            end
            default: begin
               phase <= phaseHalted;
            end
         endcase
      end
   end

   assign halted = (phase == phaseHalted);

endmodule

//--- rtl/wordMemory.sv
// Word memory of the CPU; registered CPU port from MAR and MDR, host port for loading programs and reading results
`timescale 1ns/10ps
module wordMemory (
   input  logic Clock,
   input  logic [cpuPkg::addressWidth-1:0] address,
   input  logic [cpuPkg::wordWidth-1:0] writeData,
   input  logic read,
   input  logic write,
   output logic [cpuPkg::wordWidth-1:0] readData,
   input  logic hostWrite,
   input  logic [cpuPkg::addressWidth-1:0] hostAddress,
   input  logic [cpuPkg::wordWidth-1:0] hostWriteData,
   output logic [cpuPkg::wordWidth-1:0] hostReadData
);
   import cpuPkg::*;

   logic [wordWidth-1:0] memory [2**addressWidth];

   // Host port has priority over the CPU
   always_ff @(posedge Clock) begin
      if (hostWrite) begin
         memory[hostAddress] <= hostWriteData;
      end else if (write) begin
         memory[address] <= writeData;
      end
   end

   // CPU read data appears the cycle after the read strobe
   always_ff @(posedge Clock) begin
      if (read) begin
         readData <= memory[address];
      end
   end

   assign hostReadData = memory[hostAddress];

endmodule

//--- rtl/cpuTop.sv
// Top level of the bus CPU; joins sequencer, datapath and memory and brings out the host and run pins
`timescale 1ns/10ps
module cpuTop (
   input  logic Clock,
   input  logic reset,
   input  logic run,
   input  logic hostWrite,
   input  logic [cpuPkg::addressWidth-1:0] hostAddress,
   input  logic [cpuPkg::wordWidth-1:0] hostWriteData,
   output logic [cpuPkg::wordWidth-1:0] hostReadData,
   output logic halted
);
   import cpuPkg::*;

   controlWordT control;
   statusT status;
   logic [addressWidth-1:0] memAddress;
   logic [wordWidth-1:0] memWriteData;
   logic [wordWidth-1:0] memReadData;
   logic memRead;
   logic memWrite;

   controlSequencer u_controlSequencer (
      .Clock   (Clock),
      .reset   (reset),
      .run     (run),
      .status  (status),
      .control (control),
      .halted  (halted)
   );

   dataPath u_dataPath (
      .Clock        (Clock),
      .reset        (reset),
      .control      (control),
      .status       (status),
      .memAddress   (memAddress),
      .memWriteData (memWriteData),
      .memReadData  (memReadData),
      .memRead      (memRead),
      .memWrite     (memWrite)
   );

   wordMemory u_wordMemory (
      .Clock         (Clock),
      .address       (memAddress),
      .writeData     (memWriteData),
      .read          (memRead),
      .write         (memWrite),
      .readData      (memReadData),
      .hostWrite     (hostWrite),
      .hostAddress   (hostAddress),
      .hostWriteData (hostWriteData),
      .hostReadData  (hostReadData)
   );

endmodule

//--- dv/cpuTop_assert.sv
// Assertions on the control word and halted level of the sequencer, bound into controlSequencer
`timescale 1ns/10ps
module cpuTop_assert (
   input logic Clock,
   input logic reset,
   input cpuPkg::controlWordT control,
   input logic halted
);

   memStrobesExclusive: assert property (@(posedge Clock) !(control.memRead && control.memWrite))
      else $error("memRead and memWrite are high in the same cycle");

   // From the second reset cycle on, the sequencer has left any active step
   controlQuietInReset: assert property (@(posedge Clock) reset && $past(reset) |-> control == '0)
      else $error("Control word is not zero while reset is high");

   haltedHeld: assert property (@(posedge Clock) $fell(halted) |-> $past(reset))
      else $error("halted fell without a reset");

   irAndRegisterWriteApart: assert property (@(posedge Clock) !(control.irIn && control.rIn))
      else $error("irIn and rIn are high in the same cycle");

endmodule

bind controlSequencer cpuTop_assert u_cpuTop_assert (
   .Clock   (Clock),
   .reset   (reset),
   .control (control),
   .halted  (halted)
);

//--- dv/cpuTop_tb.sv
// Testbench of the bus CPU; loads each program from the cases file, runs it and checks memory
`timescale 1ns/10ps
module cpuTop_tb;
   import cpuPkg::*;

   localparam int clockPeriod = 40;
   localparam int resetCycles = 10;
   localparam int haltHoldCycles = 6;
   localparam string casesFile = "dv/cpuTop_cases.txt";

   logic Clock;
   logic reset;
   logic run;
   logic hostWrite;
   logic [addressWidth-1:0] hostAddress;
   logic [wordWidth-1:0] hostWriteData;
   logic [wordWidth-1:0] hostReadData;
   logic halted;

   // Cases file entries in file order
   logic [7:0] entryKind [$];
   logic [addressWidth-1:0] entryAddress [$];
   logic [wordWidth-1:0] entryWord [$];

   int watchdogCycles = 0;
   int programWords = 0;
   int caseCount = 0;

   cpuTop u_cpuTop (
      .Clock         (Clock),
      .reset         (reset),
      .run           (run),
      .hostWrite     (hostWrite),
      .hostAddress   (hostAddress),
      .hostWriteData (hostWriteData),
      .hostReadData  (hostReadData),
      .halted        (halted)
   );

   initial begin
      Clock = 1'b0;
      forever begin
         #(clockPeriod / 2) Clock = ~Clock;
      end
   end

   task automatic stopWithFailure(input string reason);
      $display("%s", reason);
      $display("TESTBENCH FAILED");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic compareWord(input string signalName, input logic [wordWidth-1:0] actual,
                              input logic [wordWidth-1:0] expected);
      if (actual !== expected) begin
         $display("FAILED at %0t: %s expected %h, got %h", $time, signalName, expected, actual);
         stopWithFailure("A checked value did not match its expected value");
      end
   endtask

   task automatic readCases();
      int fd;
      int ch;
      int code;
      logic [addressWidth-1:0] address;
      logic [wordWidth-1:0] word;
      fd = $fopen(casesFile, "r");
      if (fd == 0) begin
         stopWithFailure("Could not open the cases file dv/cpuTop_cases.txt");
      end
      ch = $fgetc(fd);
      while (ch != -1) begin
         if (ch == "#") begin
            // Comment runs to the end of its line
            while (ch != "\n" && ch != -1) begin
               ch = $fgetc(fd);
            end
         end else if (ch == "P" || ch == "E") begin
            code = $fscanf(fd, "%h %h", address, word);
            if (code != 2) begin
               stopWithFailure("A P or E line of the cases file lacks its address or word");
            end
            entryKind.push_back(ch[7:0]);
            entryAddress.push_back(address);
            entryWord.push_back(word);
            if (ch == "P") begin
               programWords++;
            end
         end else if (ch == "R") begin
            entryKind.push_back(ch[7:0]);
            entryAddress.push_back('0);
            entryWord.push_back('0);
            caseCount++;
         end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
            stopWithFailure($sformatf("The cases file holds an unknown entry kind %c", ch));
         end
         ch = $fgetc(fd);
      end
      $fclose(fd);
   endtask

   task automatic writeHostWord(input logic [addressWidth-1:0] address,
                                input logic [wordWidth-1:0] word);
      @(negedge Clock);
      hostWrite = 1'b1;
      hostAddress = address;
      hostWriteData = word;
      @(negedge Clock);
      hostWrite = 1'b0;
   endtask

   // Host read is combinational and is sampled a quarter period after the address changes
   task automatic readHostWord(input logic [addressWidth-1:0] address,
                               output logic [wordWidth-1:0] word);
      @(negedge Clock);
      hostAddress = address;
      #(clockPeriod / 4);
      word = hostReadData;
   endtask

   task automatic applyReset();
      @(negedge Clock);
      reset = 1'b1;
      run = 1'b0;
      repeat (resetCycles) @(negedge Clock);
      reset = 1'b0;
   endtask

   task automatic runCase(input int first, input int last, input int caseNumber);
      int i;
      logic [wordWidth-1:0] word;
      applyReset();
      for (i = first; i < last; i++) begin
         if (entryKind[i] == "P") begin
            writeHostWord(entryAddress[i], entryWord[i]);
         end
      end
      // Run still low, so the CPU must sit idle and leave memory alone
      repeat (4) @(negedge Clock);
      compareWord($sformatf("halted before run in case %0d", caseNumber), {31'b0, halted}, '0);
      for (i = first; i < last; i++) begin
         if (entryKind[i] == "P") begin
            readHostWord(entryAddress[i], word);
            compareWord($sformatf("loaded memory[%02h] in case %0d", entryAddress[i], caseNumber),
                        word, entryWord[i]);
         end
      end
      @(negedge Clock);
      run = 1'b1;
      while (halted !== 1'b1) begin
         @(negedge Clock);
      end
      run = 1'b0;
      repeat (haltHoldCycles) @(negedge Clock);
      compareWord($sformatf("halted after halt in case %0d", caseNumber), {31'b0, halted}, 32'd1);
      for (i = first; i < last; i++) begin
         if (entryKind[i] == "E") begin
            readHostWord(entryAddress[i], word);
            compareWord($sformatf("memory[%02h] in case %0d", entryAddress[i], caseNumber),
                        word, entryWord[i]);
         end
      end
   endtask

   initial begin
      wait (watchdogCycles > 0);
      #(watchdogCycles * clockPeriod);
      stopWithFailure($sformatf("Timeout after %0d cycles, a program never halted",
                                watchdogCycles));
   end

   initial begin
      int i;
      int first;
      int caseNumber;
      reset = 1'b1;
      run = 1'b0;
      hostWrite = 1'b0;
      hostAddress = '0;
      hostWriteData = '0;
      readCases();
      if (caseCount == 0) begin
         stopWithFailure("The cases file holds no case ending in an R marker");
      end
      // Up to maxSteps cycles per phase for each word, four times over, plus load and reset time
      watchdogCycles = programWords * maxSteps * 4 + entryKind.size() * 4
                       + caseCount * (resetCycles + haltHoldCycles + 10);
      first = 0;
      caseNumber = 0;
      for (i = 0; i < entryKind.size(); i++) begin
         if (entryKind[i] == "R") begin
            caseNumber++;
            runCase(first, i, caseNumber);
            first = i + 1;
         end
      end
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

//--- dv/cpuTop_cases.txt
# Columns: kind, address, word (hex). P writes memory through the host port before the run,
# E is the word expected after halt, R ends the case and runs it from address 0
# ALU ops on words loaded from 40 and 41, results stored at 50 to 55
P 00 28800040
P 01 29000041
P 02 01890000
P 03 0A090000
P 04 12890000
P 05 1B090000
P 06 238FFFFB
P 07 0C108000
P 08 31800050
P 09 32000051
P 0A 32800052
P 0B 33000053
P 0C 33800054
P 0D 34000055
P 0E 58000000
P 40 F0000005
P 41 30000007
E 40 F0000005
E 41 30000007
E 50 2000000C
E 51 BFFFFFFE
E 52 30000005
E 53 F0000007
E 54 F0000000
E 55 40000002
R
# Base plus offset with r1 = 60, r0 written to 20 but read as zero when used as base
P 00 20800060
P 01 20000020
P 02 29080003
P 03 29800061
P 04 2A0FFFFF
P 05 31080005
P 06 31800066
P 07 32080007
P 08 30080008
P 09 58000000
P 63 13579BDF
P 61 2468ACE0
P 5F 0F1E2D3C
P 81 11111111
P 86 00000000
E 65 13579BDF
E 66 2468ACE0
E 67 0F1E2D3C
E 68 00000020
E 86 00000000
R
# jal at 1 to subroutine at 6 linking r2, jr returns to 2
P 00 20800006
P 01 38900000
P 02 31000070
P 03 31800071
P 04 58000000
P 05 30800072
P 06 21801234
P 07 41000000
P 72 00000000
E 70 00000002
E 71 00001234
E 72 00000000
R
# Four branches, each followed by a not-taken marker and a taken marker at 90 to 97
P 00 21000005
P 01 48800002
P 02 31000090
P 03 48000001
P 04 31000091
P 05 49000002
P 06 31000092
P 07 48000001
P 08 31000093
P 09 51080002
P 0A 31000094
P 0B 48000001
P 0C 31000095
P 0D 50880002
P 0E 31000096
P 0F 48000001
P 10 31000097
P 11 58000000
P 90 00000000
P 91 00000000
P 92 00000000
P 93 00000000
P 94 00000000
P 95 00000000
P 96 00000000
P 97 00000000
E 90 00000000
E 91 00000005
E 92 00000005
E 93 00000000
E 94 00000000
E 95 00000005
E 96 00000005
E 97 00000000
R
# Store after halt never runs
P 00 20800077
P 01 308000A0
P 02 58000000
P 03 308000A1
P A1 00000000
E A0 00000077
E A1 00000000
R

//--- sim.f
common/cpuPkg.sv
datapath/registerFile.sv
datapath/alu.sv
datapath/dataPath.sv
rtl/controlSequencer.sv
rtl/wordMemory.sv
rtl/cpuTop.sv
dv/cpuTop_assert.sv
dv/cpuTop_tb.sv

//--- Bender.yml
package:
  name: bus_cpu

sources:
  - files:
      - common/cpuPkg.sv
      - datapath/registerFile.sv
      - datapath/alu.sv
      - datapath/dataPath.sv
      - rtl/controlSequencer.sv
      - rtl/wordMemory.sv
      - rtl/cpuTop.sv
  - target: test
    files:
      - dv/cpuTop_assert.sv
      - dv/cpuTop_tb.sv
